// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc_plus4
    } wb_sel_e;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem_stage,
        fwd_wb_stage
    } fwd_sel_e;

    typedef struct packed {
        logic    rf_we;
        wb_sel_e wb_sel;
        alu_op_e alu_op;
        logic    src1_pc;
        logic    src2_imm;
        logic    mem_we;
        logic    mem_re;
        logic    is_branch;
        logic    br_ne;
        logic    is_jal;
        logic    ebreak;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_data;
        logic [xlen-1:0]       pc_plus4;
    } ex_mem_t;

    typedef struct packed {
        logic                  rf_we;
        wb_sel_e               wb_sel;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       load_data;
        logic [xlen-1:0]       pc_plus4;
    } mem_wb_t;

endpackage

// ==== logic/fetch_unit.sv ====
module fetch_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [cpu_pkg::xlen-1:0] im_dout,
    input  logic                     stall,
    input  logic                     if_id_flush,
    input  logic                     redirect,
    input  logic [cpu_pkg::xlen-1:0] redirect_pc,
    output logic [cpu_pkg::xlen-1:0] im_addr,
    output logic [cpu_pkg::xlen-1:0] id_inst,
    output logic [cpu_pkg::xlen-1:0] id_pc
);

    logic [cpu_pkg::xlen-1:0] pc;
    logic [cpu_pkg::xlen-1:0] pc_next;

    assign im_addr = pc;

    // always predict not taken
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= cpu_pkg::reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            id_inst <= cpu_pkg::nop_inst;
            id_pc   <= cpu_pkg::reset_pc;
        end else if (if_id_flush) begin
            id_inst <= cpu_pkg::nop_inst;
        end else if (!stall) begin
            id_inst <= im_dout;
            id_pc   <= pc;
        end
    end

endmodule

// ==== logic/pipeline_control.sv ====
module pipeline_control (
    input  logic [cpu_pkg::xlen-1:0]       id_inst,
    input  logic [cpu_pkg::xlen-1:0]       id_pc,
    input  logic                           redirect,
    input  cpu_pkg::id_ex_t                ex_stage,
    input  cpu_pkg::ex_mem_t               ex_mem,
    input  cpu_pkg::mem_wb_t               mem_wb,
    output cpu_pkg::ctrl_t                 id_ctrl,
    output logic [cpu_pkg::xlen-1:0]       id_imm,
    output logic [cpu_pkg::reg_addr_w-1:0] id_rs1,
    output logic [cpu_pkg::reg_addr_w-1:0] id_rs2,
    output logic [cpu_pkg::reg_addr_w-1:0] id_rd,
    output logic                           stall,
    output logic                           id_ex_bubble,
    output logic                           if_id_flush,
    output cpu_pkg::fwd_sel_e              fwd_a,
    output cpu_pkg::fwd_sel_e              fwd_b
);

    cpu_pkg::opcode_e opcode;
    logic [2:0]       funct3;
    logic             uses_rs1;
    logic             uses_rs2;
    logic             load_use;

    assign opcode = cpu_pkg::opcode_e'(id_inst[6:0]);
    assign funct3 = id_inst[14:12];
    assign id_rs1 = id_inst[19:15];
    assign id_rs2 = id_inst[24:20];
    assign id_rd  = id_inst[11:7];

    always_comb begin
        id_ctrl  = '0;
        id_imm   = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            cpu_pkg::opc_op: begin
                id_ctrl.rf_we = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                case (funct3)
                    3'b000: id_ctrl.alu_op = id_inst[30] ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
                    3'b010: id_ctrl.alu_op = cpu_pkg::alu_slt;
                    3'b110: id_ctrl.alu_op = cpu_pkg::alu_or;
                    3'b111: id_ctrl.alu_op = cpu_pkg::alu_and;
                    default: id_ctrl.rf_we = 1'b0;
                endcase
            end
            cpu_pkg::opc_op_imm: begin
                id_ctrl.rf_we    = 1'b1;
                id_ctrl.src2_imm = 1'b1;
                uses_rs1 = 1'b1;
                id_imm = {{20{id_inst[31]}}, id_inst[31:20]};
            end
            cpu_pkg::opc_lui: begin
                id_ctrl.rf_we    = 1'b1;
                id_ctrl.src2_imm = 1'b1;
                id_ctrl.alu_op   = cpu_pkg::alu_pass_b;
                id_imm = {id_inst[31:12], 12'b0};
            end
            cpu_pkg::opc_load: begin
                id_ctrl.rf_we    = 1'b1;
                id_ctrl.wb_sel   = cpu_pkg::wb_mem;
                id_ctrl.src2_imm = 1'b1;
                id_ctrl.mem_re   = 1'b1;
                uses_rs1 = 1'b1;
                id_imm = {{20{id_inst[31]}}, id_inst[31:20]};
            end
            cpu_pkg::opc_store: begin
                id_ctrl.mem_we   = 1'b1;
                id_ctrl.src2_imm = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                id_imm = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
            end
            cpu_pkg::opc_branch: begin
                // alu computes the target, operands go to the comparator
                id_ctrl.is_branch = 1'b1;
                id_ctrl.br_ne     = funct3[0];
                id_ctrl.src1_pc   = 1'b1;
                id_ctrl.src2_imm  = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                id_imm = {{19{id_inst[31]}}, id_inst[31], id_inst[7],
                          id_inst[30:25], id_inst[11:8], 1'b0};
            end
            cpu_pkg::opc_jal: begin
                id_ctrl.rf_we    = 1'b1;
                id_ctrl.wb_sel   = cpu_pkg::wb_pc_plus4;
                id_ctrl.is_jal   = 1'b1;
                id_ctrl.src1_pc  = 1'b1;
                id_ctrl.src2_imm = 1'b1;
                id_imm = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12],
                          id_inst[20], id_inst[30:21], 1'b0};
            end
            cpu_pkg::opc_system: id_ctrl.ebreak = id_inst[20];
            default: ;
        endcase
        // misaligned fetch never issues
        if (id_pc[1:0] != 2'b00) begin
            id_ctrl = '0;
        end
    end

    assign load_use = ex_stage.ctrl.mem_re && ex_stage.rd != '0 &&
                      ((uses_rs1 && ex_stage.rd == id_rs1) ||
                       (uses_rs2 && ex_stage.rd == id_rs2));

    assign if_id_flush  = redirect;
    assign id_ex_bubble = redirect || load_use;
    assign stall        = load_use && !redirect;

    // memory stage is younger, so it wins
    function automatic cpu_pkg::fwd_sel_e fwd_select(input logic [cpu_pkg::reg_addr_w-1:0] rs);
        if (rs == '0) begin
            return cpu_pkg::fwd_reg;
        end
        if (ex_mem.ctrl.rf_we && ex_mem.rd == rs) begin
            return cpu_pkg::fwd_mem_stage;
        end
        if (mem_wb.rf_we && mem_wb.rd == rs) begin
            return cpu_pkg::fwd_wb_stage;
        end
        return cpu_pkg::fwd_reg;
    endfunction

    always_comb begin
        fwd_a = fwd_select(ex_stage.rs1);
        fwd_b = fwd_select(ex_stage.rs2);
    end

endmodule

// ==== logic/reg_file.sv ====
module reg_file (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cpu_pkg::reg_addr_w-1:0] ra1,
    input  logic [cpu_pkg::reg_addr_w-1:0] ra2,
    input  logic                           we,
    input  logic [cpu_pkg::reg_addr_w-1:0] wa,
    input  logic [cpu_pkg::xlen-1:0]       wd,
    input  logic [cpu_pkg::reg_addr_w-1:0] dbg_addr,
    output logic [cpu_pkg::xlen-1:0]       rd1,
    output logic [cpu_pkg::xlen-1:0]       rd2,
    output logic [cpu_pkg::xlen-1:0]       dbg_data
);

    logic [cpu_pkg::xlen-1:0] regs [2**cpu_pkg::reg_addr_w];

    // write-through so decode sees the writeback value
    function automatic logic [cpu_pkg::xlen-1:0] read_port(
        input logic [cpu_pkg::reg_addr_w-1:0] ra
    );
        if (ra == '0) begin
            return '0;
        end
        if (we && wa == ra) begin
            return wd;
        end
        return regs[ra];
    endfunction

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

    assign dbg_data = regs[dbg_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**cpu_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

endmodule

// ==== logic/execute_unit.sv ====
module execute_unit (
    input  logic                           clk,
    input  logic                           reset,
    input  cpu_pkg::ctrl_t                 id_ctrl,
    input  logic [cpu_pkg::xlen-1:0]       id_pc,
    input  logic [cpu_pkg::xlen-1:0]       id_imm,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_rs2,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_rd,
    input  logic [cpu_pkg::xlen-1:0]       rs1_val,
    input  logic [cpu_pkg::xlen-1:0]       rs2_val,
    input  logic                           id_ex_bubble,
    input  cpu_pkg::fwd_sel_e              fwd_a,
    input  cpu_pkg::fwd_sel_e              fwd_b,
    input  logic [cpu_pkg::xlen-1:0]       wb_data,
    output cpu_pkg::id_ex_t                ex_stage,
    output cpu_pkg::ex_mem_t               ex_mem,
    output logic                           redirect,
    output logic [cpu_pkg::xlen-1:0]       redirect_pc
);

    logic [cpu_pkg::xlen-1:0] mem_fwd;
    logic [cpu_pkg::xlen-1:0] src_a;
    logic [cpu_pkg::xlen-1:0] src_b;
    logic [cpu_pkg::xlen-1:0] op_a;
    logic [cpu_pkg::xlen-1:0] op_b;
    logic [cpu_pkg::xlen-1:0] alu_result;
    logic                     taken;

    always_ff @(posedge clk) begin
        if (reset || id_ex_bubble) begin
            ex_stage.ctrl <= '0;
        end else begin
            ex_stage.ctrl <= id_ctrl;
        end
        ex_stage.pc      <= id_pc;
        ex_stage.rs1     <= id_rs1;
        ex_stage.rs2     <= id_rs2;
        ex_stage.rd      <= id_rd;
        ex_stage.rs1_val <= rs1_val;
        ex_stage.rs2_val <= rs2_val;
        ex_stage.imm     <= id_imm;
    end

    function automatic logic [cpu_pkg::xlen-1:0] operand(
        input cpu_pkg::fwd_sel_e        sel,
        input logic [cpu_pkg::xlen-1:0] reg_val,
        input logic [cpu_pkg::xlen-1:0] mem_val,
        input logic [cpu_pkg::xlen-1:0] wb_val
    );
        case (sel)
            cpu_pkg::fwd_mem_stage: return mem_val;
            cpu_pkg::fwd_wb_stage:  return wb_val;
            default:                return reg_val;
        endcase
    endfunction

    // a jal in memory forwards its link address
    assign mem_fwd = (ex_mem.ctrl.wb_sel == cpu_pkg::wb_pc_plus4) ? ex_mem.pc_plus4
                                                                  : ex_mem.alu_result;

    assign src_a = operand(fwd_a, ex_stage.rs1_val, mem_fwd, wb_data);
    assign src_b = operand(fwd_b, ex_stage.rs2_val, mem_fwd, wb_data);
    assign op_a  = ex_stage.ctrl.src1_pc ? ex_stage.pc : src_a;
    assign op_b  = ex_stage.ctrl.src2_imm ? ex_stage.imm : src_b;

    always_comb begin
        case (ex_stage.ctrl.alu_op)
            cpu_pkg::alu_sub:    alu_result = op_a - op_b;
            cpu_pkg::alu_and:    alu_result = op_a & op_b;
            cpu_pkg::alu_or:     alu_result = op_a | op_b;
            cpu_pkg::alu_slt:    alu_result = {{(cpu_pkg::xlen-1){1'b0}},
                                               $signed(op_a) < $signed(op_b)};
            cpu_pkg::alu_pass_b: alu_result = op_b;
            default:             alu_result = op_a + op_b;
        endcase
    end

    assign taken       = ex_stage.ctrl.is_branch && ((src_a == src_b) != ex_stage.ctrl.br_ne);
    assign redirect    = taken || ex_stage.ctrl.is_jal;
    assign redirect_pc = alu_result;

    always_ff @(posedge clk) begin
        // nothing behind an ebreak reaches memory
        if (reset || ex_mem.ctrl.ebreak) begin
            ex_mem.ctrl <= '0;
        end else begin
            ex_mem.ctrl <= ex_stage.ctrl;
        end
        ex_mem.rd         <= ex_stage.rd;
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= src_b;
        ex_mem.pc_plus4   <= ex_stage.pc + 32'd4;
    end

endmodule

// ==== logic/memory_writeback.sv ====
module memory_writeback (
    input  logic                           clk,
    input  logic                           reset,
    input  cpu_pkg::ex_mem_t               ex_mem,
    input  logic [cpu_pkg::xlen-1:0]       mem_dout,
    output logic [cpu_pkg::xlen-1:0]       mem_addr,
    output logic                           mem_we,
    output logic [cpu_pkg::xlen-1:0]       mem_din,
    output cpu_pkg::mem_wb_t               mem_wb,
    output logic                           rf_we,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_wa,
    output logic [cpu_pkg::xlen-1:0]       rf_wd,
    output logic                           ebreak
);

    logic halted;

    assign mem_addr = ex_mem.alu_result;
    assign mem_din  = ex_mem.store_data;
    assign mem_we   = ex_mem.ctrl.mem_we && !halted;
    assign ebreak   = ex_mem.ctrl.ebreak && !halted;

    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (ex_mem.ctrl.ebreak) begin
            halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.rf_we <= 1'b0;
        end else begin
            mem_wb.rf_we <= ex_mem.ctrl.rf_we && !halted;
        end
        mem_wb.wb_sel     <= ex_mem.ctrl.wb_sel;
        mem_wb.rd         <= ex_mem.rd;
        mem_wb.alu_result <= ex_mem.alu_result;
        mem_wb.load_data  <= mem_dout;
        mem_wb.pc_plus4   <= ex_mem.pc_plus4;
    end

    assign rf_we = mem_wb.rf_we;
    assign rf_wa = mem_wb.rd;

    always_comb begin
        case (mem_wb.wb_sel)
            cpu_pkg::wb_mem:      rf_wd = mem_wb.load_data;
            cpu_pkg::wb_pc_plus4: rf_wd = mem_wb.pc_plus4;
            default:              rf_wd = mem_wb.alu_result;
        endcase
    end

endmodule

// ==== logic/cpu.sv ====
module cpu (
    input  logic                             clk,
    input  logic                             reset,
    output logic [cpu_pkg::xlen-1:0]         im_addr,
    input  logic [cpu_pkg::xlen-1:0]         im_dout,
    output logic [cpu_pkg::xlen-1:0]         mem_addr,
    output logic                             mem_we,
    output logic [cpu_pkg::xlen-1:0]         mem_din,
    input  logic [cpu_pkg::xlen-1:0]         mem_dout,
    input  logic [cpu_pkg::reg_addr_w-1:0]   reg_dbg_addr,
    output logic [cpu_pkg::xlen-1:0]         reg_dbg_data,
    output logic                             ebreak
);

    logic [cpu_pkg::xlen-1:0]       id_inst;
    logic [cpu_pkg::xlen-1:0]       id_pc;
    logic                           stall;
    logic                           if_id_flush;
    logic                           id_ex_bubble;
    logic                           redirect;
    logic [cpu_pkg::xlen-1:0]       redirect_pc;
    cpu_pkg::ctrl_t                 id_ctrl;
    logic [cpu_pkg::xlen-1:0]       id_imm;
    logic [cpu_pkg::reg_addr_w-1:0] id_rs1;
    logic [cpu_pkg::reg_addr_w-1:0] id_rs2;
    logic [cpu_pkg::reg_addr_w-1:0] id_rd;
    cpu_pkg::fwd_sel_e              fwd_a;
    cpu_pkg::fwd_sel_e              fwd_b;
    logic [cpu_pkg::xlen-1:0]       rs1_val;
    logic [cpu_pkg::xlen-1:0]       rs2_val;
    cpu_pkg::id_ex_t                ex_stage;
    cpu_pkg::ex_mem_t               ex_mem;
    cpu_pkg::mem_wb_t               mem_wb;
    logic                           rf_we;
    logic [cpu_pkg::reg_addr_w-1:0] rf_wa;
    logic [cpu_pkg::xlen-1:0]       rf_wd;

    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .im_dout(im_dout), .stall(stall),
        .if_id_flush(if_id_flush), .redirect(redirect), .redirect_pc(redirect_pc),
        .im_addr(im_addr), .id_inst(id_inst), .id_pc(id_pc)
    );

    pipeline_control u_control (
        .id_inst(id_inst), .id_pc(id_pc), .redirect(redirect),
        .ex_stage(ex_stage), .ex_mem(ex_mem), .mem_wb(mem_wb),
        .id_ctrl(id_ctrl), .id_imm(id_imm), .id_rs1(id_rs1), .id_rs2(id_rs2), .id_rd(id_rd),
        .stall(stall), .id_ex_bubble(id_ex_bubble), .if_id_flush(if_id_flush),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .ra1(id_rs1), .ra2(id_rs2),
        .we(rf_we), .wa(rf_wa), .wd(rf_wd), .dbg_addr(reg_dbg_addr),
        .rd1(rs1_val), .rd2(rs2_val), .dbg_data(reg_dbg_data)
    );

    execute_unit u_execute (
        .clk(clk), .reset(reset), .id_ctrl(id_ctrl), .id_pc(id_pc), .id_imm(id_imm),
        .id_rs1(id_rs1), .id_rs2(id_rs2), .id_rd(id_rd),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .id_ex_bubble(id_ex_bubble),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .wb_data(rf_wd),
        .ex_stage(ex_stage), .ex_mem(ex_mem), .redirect(redirect), .redirect_pc(redirect_pc)
    );

    memory_writeback u_mem_wb (
        .clk(clk), .reset(reset), .ex_mem(ex_mem), .mem_dout(mem_dout),
        .mem_addr(mem_addr), .mem_we(mem_we), .mem_din(mem_din), .mem_wb(mem_wb),
        .rf_we(rf_we), .rf_wa(rf_wa), .rf_wd(rf_wd), .ebreak(ebreak)
    );

endmodule

// ==== verification/tb_cpu.sv ====
module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        reset;
    logic [31:0] im_addr;
    logic [31:0] im_dout;
    logic [31:0] mem_addr;
    logic        mem_we;
    logic [31:0] mem_din;
    logic [31:0] mem_dout;
    logic [4:0]  reg_dbg_addr;
    logic [31:0] reg_dbg_data;
    logic        ebreak;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    int          ebreak_count;
    bit          loaded;
    bit          in_reset;

    // flattened case table
    logic [31:0] insts [$];
    int          inst_first [$];
    int          inst_num [$];
    byte         chk_kind [$];
    logic [31:0] chk_addr [$];
    logic [31:0] chk_val [$];
    int          chk_first [$];
    int          chk_num [$];
    string       case_names [$];

    cpu uut (
        .clk(clk), .reset(reset), .im_addr(im_addr), .im_dout(im_dout),
        .mem_addr(mem_addr), .mem_we(mem_we), .mem_din(mem_din), .mem_dout(mem_dout),
        .reg_dbg_addr(reg_dbg_addr), .reg_dbg_data(reg_dbg_data), .ebreak(ebreak)
    );

    always #2 clk = ~clk;

    assign im_dout  = imem[im_addr[9:2]];
    assign mem_dout = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            dmem[mem_addr[9:2]] <= mem_din;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            ebreak_count <= 0;
        end else if (ebreak) begin
            ebreak_count <= ebreak_count + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // mem_we sampled mid-cycle after each reset edge
    always @(posedge clk) begin
        in_reset <= reset;
    end

    always @(negedge clk) begin
        if (in_reset) begin
            check_value("mem_we in reset", 32'(mem_we), 32'h0);
        end
    end

    // addi x0, x0, addr
    function automatic logic [31:0] imem_fill(input logic [7:0] idx);
        return {4'h0, idx, 20'h00013};
    endfunction

    function automatic logic [31:0] dmem_fill(input logic [7:0] idx);
        return {24'hda7a00, idx};
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        string       tag;
        string       name;
        logic [31:0] a;
        logic [31:0] v;
        fd = $fopen("verification/cpu_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/cpu_cases.txt");
            $display("RESULT: FAIL");
            $fatal(1, "missing case file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%s", tag);
            if (n != 1 || tag.substr(0, 0) == "#") begin
                continue;
            end
            if (tag == "case") begin
                n = $sscanf(line, "%s %s", tag, name);
                case_names.push_back(name);
                inst_first.push_back(insts.size());
                inst_num.push_back(0);
                chk_first.push_back(chk_kind.size());
                chk_num.push_back(0);
            end else if (tag == "i") begin
                n = $sscanf(line, "%s %h", tag, v);
                insts.push_back(v);
                inst_num[inst_num.size()-1]++;
            end else if (tag == "r" || tag == "m") begin
                if (tag == "r") begin
                    n = $sscanf(line, "%s %d %h", tag, a, v);
                    chk_kind.push_back("r");
                end else begin
                    n = $sscanf(line, "%s %h %h", tag, a, v);
                    chk_kind.push_back("m");
                end
                chk_addr.push_back(a);
                chk_val.push_back(v);
                chk_num[chk_num.size()-1]++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int c);
        int k;
        int idx;
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (k = 0; k < 256; k++) begin
            imem[k] = imem_fill(k[7:0]);
            dmem[k] <= dmem_fill(k[7:0]);
        end
        for (k = 0; k < inst_num[c]; k++) begin
            imem[k] = insts[inst_first[c] + k];
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        while (ebreak_count == 0) begin
            @(posedge clk);
            #1;
        end
        // drain the pipeline so that a second pulse would show
        repeat (6) @(posedge clk);
        #1;
        check_value({case_names[c], " ebreak pulses"}, ebreak_count, 32'd1);
        for (k = 0; k < chk_num[c]; k++) begin
            idx = chk_first[c] + k;
            if (chk_kind[idx] == "r") begin
                @(posedge clk);
                #1;
                reg_dbg_addr = chk_addr[idx][4:0];
                #1;
                check_value($sformatf("%s x%0d", case_names[c], chk_addr[idx]),
                            reg_dbg_data, chk_val[idx]);
            end else begin
                check_value($sformatf("%s mem[%0d]", case_names[c], chk_addr[idx]),
                            dmem[chk_addr[idx][7:0]], chk_val[idx]);
            end
        end
    endtask

    initial begin
        int limit;
        wait (loaded);
        limit = 20 * insts.size();
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, ebreak never arrived", limit);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        reg_dbg_addr = '0;
        load_cases();
        if (case_names.size() == 0) begin
            $display("case file holds no cases");
            $display("RESULT: FAIL");
            $fatal(1, "empty case file");
        end
        loaded = 1'b1;
        for (int c = 0; c < case_names.size(); c++) begin
            run_case(c);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== cpu.f ====
logic/cpu_pkg.sv
logic/fetch_unit.sv
logic/pipeline_control.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/memory_writeback.sv
logic/cpu.sv
verification/tb_cpu.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f cpu.f --top-module tb_cpu -o sim_cpu
	./obj_dir/sim_cpu

clean:
	rm -rf obj_dir

// ==== verification/cpu_cases.txt ====
# case <name> | i <instruction hex> | r <reg decimal> <expected hex>
# m <word address hex> <expected hex>, unloaded data words read da7a00 followed by the address
case arith
i 00500093
i 00C00113
i FFD00193
i 12345237
i 002082B3
i 40208333
i 0020F3B3
i 0020E433
i 0011A4B3
i 0030A533
i 00100073
r 1 00000005
r 2 0000000C
r 3 FFFFFFFD
r 4 12345000
r 5 00000011
r 6 FFFFFFF9
r 7 00000004
r 8 0000000D
r 9 00000001
r 10 00000000
case fwd_load_store
i 00700093
i 00108133
i 001101B3
i 00302423
i 00802203
i 001202B3
i 00502623
i 00100073
i 00102823
r 2 0000000E
r 3 00000015
r 4 00000015
r 5 0000001C
m 2 00000015
m 3 0000001C
m 4 DA7A0004
case branch_jump
i 00100093
i 00100113
i 00208663
i 00100513
i 00100593
i 00009663
i 00100613
i 00100693
i 00008463
i 00300193
i 00C002EF
i 00100713
i 00100793
i 00400213
i 00100073
r 1 00000001
r 3 00000003
r 4 00000004
r 5 0000002C
r 10 00000000
r 11 00000000
r 12 00000000
r 13 00000000
r 14 00000000
r 15 00000000
